//--- hw/decode_pkg.sv
// Decode stage 1 shared definitions
// Encodings for operand size and kind, ALU and stack operations,
// flag classes, segments and microcode entries
package decode_pkg;

   // Default program counter width
   localparam int iaddr_w = 32;
   // Sign-extended immediate and displacement width
   localparam int data_w = 32;
   // Register number width
   localparam int reg_w = 3;

   typedef enum logic [2:0] {
      SIZE_8  = 3'd0,
      SIZE_16 = 3'd1,
      SIZE_32 = 3'd2
   } size_e;

   typedef enum logic [2:0] {
      OPK_NONE = 3'd0,
      OPK_REG  = 3'd1,
      OPK_MEM  = 3'd2,
      OPK_IMM  = 3'd3
   } op_kind_e;

   // x86 group codes, ADC (2) and SBB (3) left out
   typedef enum logic [3:0] {
      ALU_ADD     = 4'd0,
      ALU_OR      = 4'd1,
      ALU_AND     = 4'd4,
      ALU_SUB     = 4'd5,
      ALU_XOR     = 4'd6,
      ALU_CMP     = 4'd7,
      ALU_MOV     = 4'd8,
      ALU_NOP     = 4'd9,
      ALU_ILLEGAL = 4'd15
   } alu_op_e;

   typedef enum logic [1:0] {
      STK_NONE = 2'd0,
      STK_PUSH = 2'd1,
      STK_POP  = 2'd2
   } stack_op_e;

   typedef enum logic [1:0] {
      FL_NONE  = 2'd0,
      FL_ARITH = 2'd1,
      FL_LOGIC = 2'd2
   } flag_cls_e;

   // x86 segment register order
   typedef enum logic [2:0] {
      SEG_ES = 3'd0,
      SEG_CS = 3'd1,
      SEG_SS = 3'd2,
      SEG_DS = 3'd3,
      SEG_FS = 3'd4,
      SEG_GS = 3'd5
   } seg_e;

   typedef enum logic [2:0] {
      ROM_LEAVE = 3'd0,
      ROM_PUSHA = 3'd1
   } rom_entry_e;

endpackage

//--- hw/imm_disp_split.sv
// Displacement and immediate split
// Displacement sits in the low bytes, immediate directly above it,
// both sign-extended by their byte counts
`timescale 1ns/1ps

module imm_disp_split (
   input  logic [63:0]                     displace_n_imm,
   input  logic [3:0]                      disp_bytes,
   input  logic [3:0]                      imm_bytes,
   output logic [decode_pkg::data_w-1:0]   imm,
   output logic [decode_pkg::data_w-1:0]   disp
);

   localparam int W = decode_pkg::data_w;

   logic [63:0] above_disp;

   function automatic logic [W-1:0] sext(input logic [W-1:0] raw, input logic [3:0] n);
      case (n)
         4'd1:    sext = {{(W-8){raw[7]}}, raw[7:0]};
         4'd2:    sext = {{(W-16){raw[15]}}, raw[15:0]};
         4'd4:    sext = raw;
         default: sext = '0;
      endcase
   endfunction

   // Drop the displacement bytes to line up the immediate
   assign above_disp = displace_n_imm >> {disp_bytes, 3'b000};

   assign disp = sext(displace_n_imm[W-1:0], disp_bytes);
   assign imm  = sext(above_disp[W-1:0], imm_bytes);

endmodule

//--- hw/prefix_decode.sv
// Prefix decoder
// Masks the prefix bytes by count and finds segment override,
// REP and operand-size override
`timescale 1ns/1ps

module prefix_decode (
   input  logic [23:0]        prefix,
   input  logic [1:0]         prefix_bytes,
   output decode_pkg::seg_e   seg_override,
   output logic               seg_override_valid,
   output logic               rep,
   output logic               size_override
);

   logic [23:0] mask_prefix;

   // First byte is the highest one
   always_comb begin
      case (prefix_bytes)
         2'd0:    mask_prefix = 24'h0;
         2'd1:    mask_prefix = {prefix[23:16], 16'h0};
         2'd2:    mask_prefix = {prefix[23:8], 8'h0};
         default: mask_prefix = prefix;
      endcase
   end

   always_comb begin
      logic [7:0] b;
      seg_override       = decode_pkg::SEG_ES;
      seg_override_valid = 1'b0;
      rep                = 1'b0;
      size_override      = 1'b0;
      // Walk in prefix order so a later segment prefix wins
      for (int i = 2; i >= 0; i--) begin
         b = mask_prefix[i*8 +: 8];
         case (b)
            8'h26, 8'h2e, 8'h36, 8'h3e: begin
               seg_override       = decode_pkg::seg_e'({1'b0, b[4:3]});
               seg_override_valid = 1'b1;
            end
            8'h64, 8'h65: begin
               seg_override       = decode_pkg::seg_e'({2'b10, b[0]});
               seg_override_valid = 1'b1;
            end
            8'hf3:   rep = 1'b1;
            8'h66:   size_override = 1'b1;
            default: ;
         endcase
      end
   end

endmodule

//--- hw/op_and_rm_decode.sv
// Opcode and ModRM decoder
// Maps the supported one-byte opcodes to ALU, stack and flag controls,
// everything else decodes as illegal
`timescale 1ns/1ps

module op_and_rm_decode (
   input  logic [15:0]                    opcode,
   input  logic [1:0]                     opcode_bytes,
   input  logic [7:0]                     modrm,
   input  logic                           size_override,
   output decode_pkg::size_e              size,
   output logic                           set_d_flag,
   output logic                           clear_d_flag,
   output decode_pkg::op_kind_e           op0,
   output decode_pkg::op_kind_e           op1,
   output logic [decode_pkg::reg_w-1:0]   op0_reg,
   output logic [decode_pkg::reg_w-1:0]   op1_reg,
   output decode_pkg::alu_op_e            alu_op,
   output decode_pkg::flag_cls_e          flag_cls,
   output decode_pkg::stack_op_e          stack_op,
   output logic                           is_hlt
);

   logic [7:0]                 op;
   logic                       one_byte;
   logic [2:0]                 grp;
   decode_pkg::op_kind_e       rm_kind;

   // First opcode byte sits in the upper half
   assign op       = opcode[15:8];
   assign one_byte = (opcode_bytes == 2'd1);
   assign grp      = op[5:3];
   assign rm_kind  = (modrm[7:6] == 2'b11) ? decode_pkg::OPK_REG : decode_pkg::OPK_MEM;

   always_comb begin
      size         = decode_pkg::SIZE_32;
      set_d_flag   = 1'b0;
      clear_d_flag = 1'b0;
      op0          = decode_pkg::OPK_NONE;
      op1          = decode_pkg::OPK_NONE;
      op0_reg      = '0;
      op1_reg      = '0;
      alu_op       = decode_pkg::ALU_ILLEGAL;
      flag_cls     = decode_pkg::FL_NONE;
      stack_op     = decode_pkg::STK_NONE;
      is_hlt       = 1'b0;

      if (one_byte) begin
         if (op[7:6] == 2'b00 && !op[2] && grp != 3'd2 && grp != 3'd3) begin
            alu_op   = decode_pkg::alu_op_e'({1'b0, grp});
            flag_cls = (grp == 3'd1 || grp == 3'd4 || grp == 3'd6) ?
                       decode_pkg::FL_LOGIC : decode_pkg::FL_ARITH;
            if (!op[0])
               size = decode_pkg::SIZE_8;
            else if (size_override)
               size = decode_pkg::SIZE_16;
            // Direction bit picks which side the r/m operand lands on
            if (!op[1]) begin
               op0     = rm_kind;
               op0_reg = modrm[2:0];
               op1     = decode_pkg::OPK_REG;
               op1_reg = modrm[5:3];
            end else begin
               op0     = decode_pkg::OPK_REG;
               op0_reg = modrm[5:3];
               op1     = rm_kind;
               op1_reg = modrm[2:0];
            end
         end else if (op[7:4] == 4'h5) begin
            alu_op   = decode_pkg::ALU_NOP;
            stack_op = op[3] ? decode_pkg::STK_POP : decode_pkg::STK_PUSH;
            op0      = decode_pkg::OPK_REG;
            op0_reg  = op[2:0];
         end else if (op == 8'hfc) begin
            alu_op       = decode_pkg::ALU_NOP;
            clear_d_flag = 1'b1;
         end else if (op == 8'hfd) begin
            alu_op     = decode_pkg::ALU_NOP;
            set_d_flag = 1'b1;
         end else if (op == 8'hf4) begin
            alu_op = decode_pkg::ALU_NOP;
            is_hlt = 1'b1;
         end
      end
   end

endmodule

//--- hw/rom_sequencer.sv
// Microcode sequencer
// Steps through the micro-ops of LEAVE and PUSHA, one per load
`timescale 1ns/1ps

module rom_sequencer (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           flush,
   input  logic                           start,
   input  decode_pkg::rom_entry_e         entry,
   input  logic                           load,
   output logic                           last,
   output decode_pkg::op_kind_e           op0,
   output decode_pkg::op_kind_e           op1,
   output logic [decode_pkg::reg_w-1:0]   op0_reg,
   output logic [decode_pkg::reg_w-1:0]   op1_reg,
   output decode_pkg::alu_op_e            alu_op,
   output decode_pkg::stack_op_e          stack_op,
   output decode_pkg::size_e              size
);

   logic [2:0]                cnt;
   logic                      busy;
   decode_pkg::rom_entry_e    entry_q;
   decode_pkg::rom_entry_e    cur_entry;

   always_ff @(posedge clk) begin
      if (rst || flush || !start) begin
         cnt  <= '0;
         busy <= 1'b0;
      end else if (load) begin
         cnt  <= last ? 3'd0 : cnt + 3'd1;
         busy <= !last;
      end
   end

   // Entry held from the first micro-op on
   always_ff @(posedge clk) begin
      if (start && load && !busy)
         entry_q <= entry;
   end

   assign cur_entry = busy ? entry_q : entry;
   assign size      = decode_pkg::SIZE_32;

   always_comb begin
      last     = 1'b1;
      op0      = decode_pkg::OPK_NONE;
      op1      = decode_pkg::OPK_NONE;
      op0_reg  = '0;
      op1_reg  = '0;
      alu_op   = decode_pkg::ALU_ILLEGAL;
      stack_op = decode_pkg::STK_NONE;
      case (cur_entry)
         decode_pkg::ROM_LEAVE: begin
            last    = (cnt == 3'd1);
            op0     = decode_pkg::OPK_REG;
            op0_reg = (cnt == 3'd0) ? 3'd4 : 3'd5;
            if (cnt == 3'd0) begin
               // ESP <- EBP
               alu_op  = decode_pkg::ALU_MOV;
               op1     = decode_pkg::OPK_REG;
               op1_reg = 3'd5;
            end else begin
               alu_op   = decode_pkg::ALU_NOP;
               stack_op = decode_pkg::STK_POP;
            end
         end
         decode_pkg::ROM_PUSHA: begin
            last     = (cnt == 3'd7);
            alu_op   = decode_pkg::ALU_NOP;
            stack_op = decode_pkg::STK_PUSH;
            op0      = decode_pkg::OPK_REG;
            op0_reg  = cnt;
         end
         default: ;
      endcase
   end

endmodule

//--- hw/decode_stage_1.sv
// Decode stage 1
// Picks the plain decode or the microcode path and registers the result
// in a valid/ready output slot, with halt and flush control
`timescale 1ns/1ps

module decode_stage_1 #(
   parameter int IADDRW = decode_pkg::iaddr_w
) (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  flush,
   input  logic                                  handle_int,
   output logic                                  halt,
   input  logic                                  s0_valid,
   output logic                                  s0_ready,
   input  logic [23:0]                           s0_prefix,
   input  logic [1:0]                            s0_prefix_bytes,
   input  logic [15:0]                           s0_opcode,
   input  logic [1:0]                            s0_opcode_bytes,
   input  logic [15:0]                           s0_addressing,
   input  logic [63:0]                           s0_displace_n_imm,
   input  logic [3:0]                            s0_displacement_bytes,
   input  logic [3:0]                            s0_immediate_bytes,
   input  logic                                  s0_rom_in_control,
   input  decode_pkg::rom_entry_e                s0_rom_control,
   input  logic [IADDRW-1:0]                     s0_pc,
   input  logic                                  s0_branch_taken,
   output logic                                  s1_valid,
   input  logic                                  s1_ready,
   output decode_pkg::size_e                     s1_size,
   output logic                                  s1_set_d_flag,
   output logic                                  s1_clear_d_flag,
   output decode_pkg::op_kind_e                  s1_op0,
   output decode_pkg::op_kind_e                  s1_op1,
   output logic [decode_pkg::reg_w-1:0]          s1_op0_reg,
   output logic [decode_pkg::reg_w-1:0]          s1_op1_reg,
   output logic [7:0]                            s1_modrm,
   output logic [7:0]                            s1_sib,
   output logic [decode_pkg::data_w-1:0]         s1_imm,
   output logic [decode_pkg::data_w-1:0]         s1_disp,
   output decode_pkg::alu_op_e                   s1_alu_op,
   output decode_pkg::flag_cls_e                 s1_flag_cls,
   output decode_pkg::stack_op_e                 s1_stack_op,
   output decode_pkg::seg_e                      s1_seg_override,
   output logic                                  s1_seg_override_valid,
   output logic                                  s1_repeat,
   output logic [IADDRW-1:0]                     s1_pc,
   output logic                                  s1_branch_taken
);

   decode_pkg::seg_e                   dec_seg;
   logic                               dec_seg_valid, dec_rep, dec_size_ovr;
   logic [decode_pkg::data_w-1:0]      dec_imm, dec_disp;
   decode_pkg::size_e                  dec_size, rom_size;
   logic                               dec_set_d, dec_clear_d, dec_is_hlt;
   decode_pkg::op_kind_e               dec_op0, dec_op1, rom_op0, rom_op1;
   logic [decode_pkg::reg_w-1:0]       dec_op0_reg, dec_op1_reg, rom_op0_reg, rom_op1_reg;
   decode_pkg::alu_op_e                dec_alu_op, rom_alu_op;
   decode_pkg::flag_cls_e              dec_flag_cls;
   decode_pkg::stack_op_e              dec_stack_op, rom_stack_op;
   logic                               rom_last, can_load, load;

   prefix_decode u_prefix (
      .prefix(s0_prefix), .prefix_bytes(s0_prefix_bytes), .seg_override(dec_seg),
      .seg_override_valid(dec_seg_valid), .rep(dec_rep), .size_override(dec_size_ovr)
   );

   imm_disp_split u_imm_disp (
      .displace_n_imm(s0_displace_n_imm), .disp_bytes(s0_displacement_bytes),
      .imm_bytes(s0_immediate_bytes), .imm(dec_imm), .disp(dec_disp)
   );

   op_and_rm_decode u_op_rm (
      .opcode(s0_opcode), .opcode_bytes(s0_opcode_bytes), .modrm(s0_addressing[15:8]),
      .size_override(dec_size_ovr), .size(dec_size), .set_d_flag(dec_set_d),
      .clear_d_flag(dec_clear_d), .op0(dec_op0), .op1(dec_op1), .op0_reg(dec_op0_reg),
      .op1_reg(dec_op1_reg), .alu_op(dec_alu_op), .flag_cls(dec_flag_cls),
      .stack_op(dec_stack_op), .is_hlt(dec_is_hlt)
   );

   rom_sequencer u_rom (
      .clk(clk), .rst(rst), .flush(flush), .start(s0_valid && s0_rom_in_control),
      .entry(s0_rom_control), .load(load && s0_rom_in_control), .last(rom_last),
      .op0(rom_op0), .op1(rom_op1), .op0_reg(rom_op0_reg), .op1_reg(rom_op1_reg),
      .alu_op(rom_alu_op), .stack_op(rom_stack_op), .size(rom_size)
   );

   // Slot takes data when empty or draining this cycle
   assign can_load = !s1_valid || s1_ready;
   assign load     = s0_valid && can_load && !halt && !flush;
   assign s0_ready = can_load && !halt && !flush && (!s0_rom_in_control || rom_last);

   always_ff @(posedge clk) begin
      if (rst || flush)
         s1_valid <= 1'b0;
      else if (can_load)
         s1_valid <= load;
   end

   always_ff @(posedge clk) begin
      if (rst || handle_int)
         halt <= 1'b0;
      else if (load && !s0_rom_in_control && dec_is_hlt)
         halt <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (load) begin
         s1_pc <= s0_pc;
         if (s0_rom_in_control) begin
            // Micro-ops carry no prefix, immediate or addressing bytes
            {s1_size, s1_op0, s1_op1} <= {rom_size, rom_op0, rom_op1};
            {s1_op0_reg, s1_op1_reg}  <= {rom_op0_reg, rom_op1_reg};
            {s1_alu_op, s1_stack_op}  <= {rom_alu_op, rom_stack_op};
            s1_flag_cls           <= decode_pkg::FL_NONE;
            s1_seg_override       <= decode_pkg::SEG_ES;
            {s1_set_d_flag, s1_clear_d_flag, s1_seg_override_valid} <= 3'b000;
            {s1_repeat, s1_branch_taken}                           <= 2'b00;
            {s1_modrm, s1_sib, s1_imm, s1_disp}                    <= '0;
         end else begin
            {s1_size, s1_op0, s1_op1} <= {dec_size, dec_op0, dec_op1};
            {s1_op0_reg, s1_op1_reg}  <= {dec_op0_reg, dec_op1_reg};
            {s1_alu_op, s1_stack_op}  <= {dec_alu_op, dec_stack_op};
            s1_flag_cls           <= dec_flag_cls;
            s1_seg_override       <= dec_seg;
            {s1_set_d_flag, s1_clear_d_flag, s1_seg_override_valid} <=
               {dec_set_d, dec_clear_d, dec_seg_valid};
            {s1_repeat, s1_branch_taken}                           <= {dec_rep, s0_branch_taken};
            {s1_modrm, s1_sib, s1_imm, s1_disp} <= {s0_addressing, dec_imm, dec_disp};
         end
      end
   end

endmodule

//--- testbench/decode_model.svh
// Reference model for decode stage 1
// Builds the expected output record(s) of one stage 0 instruction

typedef struct packed {
   logic [23:0] prefix;
   logic [1:0]  prefix_bytes;
   logic [15:0] opcode;
   logic [1:0]  opcode_bytes;
   logic [15:0] addressing;
   logic [63:0] dni;
   logic [3:0]  disp_bytes, imm_bytes;
   logic        rom;
   logic [2:0]  entry;
   logic [31:0] pc;
   logic        bt;
} instr_t;

typedef struct packed {
   logic [2:0]  size, op0, op1, op0_reg, op1_reg, seg;
   logic        set_d, clr_d, seg_v, rep, bt;
   logic [7:0]  modrm, sib;
   logic [31:0] imm, disp, pc;
   logic [3:0]  alu;
   logic [1:0]  fl, stk;
} rec_t;

function automatic logic [31:0] sign_ext(input logic [63:0] v, input logic [3:0] n);
   case (n)
      4'd1:    return {{24{v[7]}}, v[7:0]};
      4'd2:    return {{16{v[15]}}, v[15:0]};
      4'd4:    return v[31:0];
      default: return 32'h0;
   endcase
endfunction

function automatic int micro_op_count(input instr_t ins);
   if (!ins.rom)
      return 1;
   return (ins.entry == decode_pkg::ROM_LEAVE) ? 2 : 8;
endfunction

function automatic rec_t expected_rec(input instr_t ins, input int k);
   rec_t r;
   logic [7:0] op;
   logic [7:0] b;
   logic ovr;
   logic [2:0] g;
   logic [2:0] rm;
   r = '0;
   r.pc = ins.pc;
   r.size = decode_pkg::SIZE_32;
   if (ins.rom) begin
      r.op0 = decode_pkg::OPK_REG;
      if (ins.entry == decode_pkg::ROM_LEAVE && k == 0) begin
         r.alu = decode_pkg::ALU_MOV;
         {r.op0_reg, r.op1, r.op1_reg} = {3'd4, 3'(decode_pkg::OPK_REG), 3'd5};
      end else if (ins.entry == decode_pkg::ROM_LEAVE) begin
         {r.alu, r.stk, r.op0_reg} = {4'(decode_pkg::ALU_NOP), 2'(decode_pkg::STK_POP), 3'd5};
      end else begin
         {r.alu, r.stk, r.op0_reg} = {4'(decode_pkg::ALU_NOP), 2'(decode_pkg::STK_PUSH), 3'(k)};
      end
      return r;
   end
   r.bt = ins.bt;
   {r.modrm, r.sib} = ins.addressing;
   r.disp = sign_ext(ins.dni, ins.disp_bytes);
   r.imm = sign_ext(ins.dni >> (8 * ins.disp_bytes), ins.imm_bytes);
   ovr = 1'b0;
   // Prefix bytes in order, a later segment prefix replaces an earlier one
   for (int j = 0; j < ins.prefix_bytes; j++) begin
      b = ins.prefix[23 - 8*j -: 8];
      case (b)
         8'h26: {r.seg, r.seg_v} = {3'd0, 1'b1};
         8'h2e: {r.seg, r.seg_v} = {3'd1, 1'b1};
         8'h36: {r.seg, r.seg_v} = {3'd2, 1'b1};
         8'h3e: {r.seg, r.seg_v} = {3'd3, 1'b1};
         8'h64: {r.seg, r.seg_v} = {3'd4, 1'b1};
         8'h65: {r.seg, r.seg_v} = {3'd5, 1'b1};
         8'hf3: r.rep = 1'b1;
         8'h66: ovr = 1'b1;
         default: ;
      endcase
   end
   op = ins.opcode[15:8];
   g = op[5:3];
   rm = (r.modrm[7:6] == 2'b11) ? 3'(decode_pkg::OPK_REG) : 3'(decode_pkg::OPK_MEM);
   r.alu = decode_pkg::ALU_ILLEGAL;
   if (ins.opcode_bytes != 2'd1)
      return r;
   if (op < 8'h40 && !op[2] && g != 3'd2 && g != 3'd3) begin
      r.alu = {1'b0, g};
      r.fl = (g == 1 || g == 4 || g == 6) ? decode_pkg::FL_LOGIC : decode_pkg::FL_ARITH;
      if (!op[0])
         r.size = decode_pkg::SIZE_8;
      else if (ovr)
         r.size = decode_pkg::SIZE_16;
      if (!op[1])
         {r.op0, r.op0_reg, r.op1, r.op1_reg} = {rm, r.modrm[2:0], 3'd1, r.modrm[5:3]};
      else
         {r.op0, r.op0_reg, r.op1, r.op1_reg} = {3'd1, r.modrm[5:3], rm, r.modrm[2:0]};
   end else if (op[7:4] == 4'h5) begin
      r.alu = decode_pkg::ALU_NOP;
      r.stk = op[3] ? decode_pkg::STK_POP : decode_pkg::STK_PUSH;
      {r.op0, r.op0_reg} = {3'(decode_pkg::OPK_REG), op[2:0]};
   end else if (op == 8'hfc || op == 8'hfd || op == 8'hf4) begin
      r.alu = decode_pkg::ALU_NOP;
      r.clr_d = (op == 8'hfc);
      r.set_d = (op == 8'hfd);
   end
   return r;
endfunction

//--- testbench/tb_decode_stage_1.sv
// Testbench for decode stage 1
// Random and directed instruction streams checked against a reference model
`timescale 1ns/1ps

module tb_decode_stage_1;
   `include "decode_model.svh"

   // Instructions offered per test, in test order
   localparam int PLANNED = 30 + 30 + 14 + 4 + 50 + 5;
   localparam int LIMIT = 4 * PLANNED + 200;

   logic clk = 1'b0;
   logic rst, flush, handle_int, s0_valid, s1_ready, s0_rom_in_control, s0_branch_taken;
   logic [23:0] s0_prefix;
   logic [1:0]  s0_prefix_bytes, s0_opcode_bytes;
   logic [15:0] s0_opcode, s0_addressing;
   logic [63:0] s0_displace_n_imm;
   logic [3:0]  s0_displacement_bytes, s0_immediate_bytes;
   logic [31:0] s0_pc, s1_pc, s1_imm, s1_disp;
   decode_pkg::rom_entry_e s0_rom_control;
   logic halt, s0_ready, s1_valid, s1_set_d, s1_clr_d, s1_seg_v, s1_rep, s1_bt;
   logic [2:0]  s1_size, s1_op0, s1_op1, s1_op0_reg, s1_op1_reg, s1_seg;
   logic [7:0]  s1_modrm, s1_sib;
   logic [3:0]  s1_alu;
   logic [1:0]  s1_fl, s1_stk, ready_mode;
   logic [15:0] lfsr = 16'd86;
   logic [15:0] ready_lfsr = 16'd86;
   // Stack, flag and unsupported one-byte opcodes
   logic [7:0]  misc_ops [12] = '{8'h50, 8'h57, 8'h58, 8'h5d, 8'hfc, 8'hfd,
                                  8'h10, 8'h1a, 8'h04, 8'h90, 8'hc3, 8'h3f};
   rec_t exp_q[$];
   string cur_test;
   int errors = 0, test_err, tests_ok = 0, tests_bad = 0, cycles = 0, waited;
   instr_t ins;

   decode_stage_1 #(.IADDRW(32)) decode_stage_1_inst (
      .clk(clk), .rst(rst), .flush(flush), .handle_int(handle_int), .halt(halt),
      .s0_valid(s0_valid), .s0_ready(s0_ready), .s0_prefix(s0_prefix),
      .s0_prefix_bytes(s0_prefix_bytes), .s0_opcode(s0_opcode), .s0_opcode_bytes(s0_opcode_bytes),
      .s0_addressing(s0_addressing), .s0_displace_n_imm(s0_displace_n_imm),
      .s0_displacement_bytes(s0_displacement_bytes), .s0_immediate_bytes(s0_immediate_bytes),
      .s0_rom_in_control(s0_rom_in_control), .s0_rom_control(s0_rom_control), .s0_pc(s0_pc),
      .s0_branch_taken(s0_branch_taken), .s1_valid(s1_valid), .s1_ready(s1_ready),
      .s1_size(s1_size), .s1_set_d_flag(s1_set_d), .s1_clear_d_flag(s1_clr_d), .s1_op0(s1_op0),
      .s1_op1(s1_op1), .s1_op0_reg(s1_op0_reg), .s1_op1_reg(s1_op1_reg), .s1_modrm(s1_modrm),
      .s1_sib(s1_sib), .s1_imm(s1_imm), .s1_disp(s1_disp), .s1_alu_op(s1_alu),
      .s1_flag_cls(s1_fl), .s1_stack_op(s1_stk), .s1_seg_override(s1_seg),
      .s1_seg_override_valid(s1_seg_v), .s1_repeat(s1_rep), .s1_pc(s1_pc),
      .s1_branch_taken(s1_bt)
   );

   always #10 clk = ~clk;

   // Galois LFSR step
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0);
   endfunction

   // Instruction stream bits, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [3:0] rand_count();
      logic [1:0] c;
      c = rand_bits(2);
      return (c == 2'd3) ? 4'd4 : {2'b00, c};
   endfunction

   function automatic logic [7:0] rand_prefix_byte();
      logic [3:0] p;
      p = rand_bits(4);
      case (p)
         0: return 8'h26;
         1: return 8'h2e;
         2: return 8'h36;
         3: return 8'h3e;
         4: return 8'h64;
         5: return 8'h65;
         6: return 8'hf3;
         7, 8: return 8'h66;
         default: return rand_bits(8);
      endcase
   endfunction

   function automatic instr_t plain_instr(input logic [7:0] op);
      instr_t r;
      r = '0;
      r.opcode = {op, 8'(rand_bits(8))};
      r.opcode_bytes = 2'd1;
      r.addressing = rand_bits(16);
      r.dni = {rand_bits(32), rand_bits(32)};
      r.pc = rand_bits(32);
      r.bt = rand_bits(1);
      return r;
   endfunction

   function automatic instr_t alu_instr(input bit with_prefix);
      instr_t r;
      logic [2:0] g;
      g = rand_bits(3);
      if (g == 3'd2 || g == 3'd3)
         g = g + 3'd4;
      r = plain_instr({2'b00, g, 1'b0, 2'(rand_bits(2))});
      if (with_prefix) begin
         r.prefix = {rand_prefix_byte(), rand_prefix_byte(), rand_prefix_byte()};
         r.prefix_bytes = rand_bits(2);
         r.disp_bytes = rand_count();
         r.imm_bytes = rand_count();
      end
      return r;
   endfunction

   function automatic instr_t rom_instr(input logic [2:0] entry);
      instr_t r;
      r = plain_instr(8'h90);
      r.rom = 1'b1;
      r.entry = entry;
      return r;
   endfunction

   task automatic check_field(input string name, input logic [63:0] e, input logic [63:0] a);
      if (e !== a) begin
         $display("Mismatch %s %s: expected %0h, actual %0h", cur_test, name, e, a);
         errors++;
      end
   endtask

   task automatic fail_check(input string what);
      $display("%s: %s", cur_test, what);
      errors++;
   endtask

   task automatic present(input instr_t t);
      for (int k = 0; k < micro_op_count(t); k++)
         exp_q.push_back(expected_rec(t, k));
      {s0_prefix, s0_prefix_bytes, s0_opcode, s0_opcode_bytes} =
         {t.prefix, t.prefix_bytes, t.opcode, t.opcode_bytes};
      {s0_addressing, s0_displace_n_imm} = {t.addressing, t.dni};
      {s0_displacement_bytes, s0_immediate_bytes} = {t.disp_bytes, t.imm_bytes};
      s0_rom_in_control = t.rom;
      s0_rom_control = decode_pkg::rom_entry_e'(t.entry);
      {s0_pc, s0_branch_taken} = {t.pc, t.bt};
      s0_valid = 1'b1;
   endtask

   // Counts the edges until s0 is consumed
   task automatic wait_accept(output int n);
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!s0_ready);
      @(negedge clk);
      s0_valid = 1'b0;
   endtask

   task automatic offer(input instr_t t, input bit check_latency);
      present(t);
      wait_accept(waited);
      if (check_latency && (!s1_valid || s1_pc !== t.pc))
         fail_check("record not on s1 one cycle after acceptance");
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_err = errors;
   endtask

   task automatic end_test();
      while (exp_q.size() != 0)
         @(negedge clk);
      if (errors == test_err)
         tests_ok++;
      else
         tests_bad++;
      $display("%s: %s (%0d errors)", cur_test, (errors == test_err) ? "pass" : "fail",
               errors - test_err);
   endtask

   // Random ready has its own LFSR so the instruction stream stays fixed
   always @(negedge clk) begin
      if (ready_mode == 2'd1) begin
         ready_lfsr = lfsr_next(ready_lfsr);
         s1_ready = ready_lfsr[0];
      end else begin
         s1_ready = (ready_mode == 2'd0);
      end
   end

   // Scoreboard compare at every s1 transfer
   always @(posedge clk) begin
      rec_t e;
      if (!rst && s1_valid && s1_ready) begin
         if (exp_q.size() == 0) begin
            fail_check("record on s1 with nothing expected");
         end else begin
            e = exp_q.pop_front();
            check_field("size", e.size, s1_size);
            check_field("op0", e.op0, s1_op0);
            check_field("op1", e.op1, s1_op1);
            check_field("op0_reg", e.op0_reg, s1_op0_reg);
            check_field("op1_reg", e.op1_reg, s1_op1_reg);
            check_field("set_d", e.set_d, s1_set_d);
            check_field("clear_d", e.clr_d, s1_clr_d);
            check_field("modrm", e.modrm, s1_modrm);
            check_field("sib", e.sib, s1_sib);
            check_field("imm", e.imm, s1_imm);
            check_field("disp", e.disp, s1_disp);
            check_field("alu_op", e.alu, s1_alu);
            check_field("flag_cls", e.fl, s1_fl);
            check_field("stack_op", e.stk, s1_stk);
            check_field("seg", e.seg, s1_seg);
            check_field("seg_valid", e.seg_v, s1_seg_v);
            check_field("repeat", e.rep, s1_rep);
            check_field("pc", e.pc, s1_pc);
            check_field("branch_taken", e.bt, s1_bt);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   initial begin
      {rst, flush, handle_int, s0_valid, s1_ready, ready_mode} = {4'b1000, 1'b1, 2'd0};
      present('0);
      s0_valid = 1'b0;
      exp_q.delete();
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      start_test("alu_forms");
      repeat (30)
         offer(alu_instr(1'b0), 1'b1);
      end_test();

      start_test("prefix_imm_disp");
      repeat (30)
         offer(alu_instr(1'b1), 1'b1);
      end_test();

      start_test("stack_flags_illegal");
      foreach (misc_ops[i])
         offer(plain_instr(misc_ops[i]), 1'b1);
      ins = alu_instr(1'b0);
      ins.opcode_bytes = 2'd2;
      offer(ins, 1'b1);
      ins.opcode = 16'h0f05;
      offer(ins, 1'b1);
      end_test();

      start_test("microcode");
      for (int i = 0; i < 4; i++) begin
         ins = rom_instr(3'(i % 2));
         offer(ins, 1'b0);
         if (waited != micro_op_count(ins))
            fail_check($sformatf("s0 consumed after %0d edges, not with the last micro-op",
                                 waited));
      end
      end_test();

      start_test("backpressure");
      ready_mode = 2'd1;
      repeat (50) begin
         case (rand_bits(3))
            0: offer(rom_instr(3'(rand_bits(1))), 1'b0);
            1: offer(plain_instr(8'h50 + 8'(rand_bits(4))), 1'b0);
            default: offer(alu_instr(1'b1), 1'b0);
         endcase
      end
      ready_mode = 2'd0;
      end_test();

      start_test("halt_flush");
      offer(plain_instr(8'hf4), 1'b1);
      if (!halt)
         fail_check("halt not raised after HLT");
      present(alu_instr(1'b0));
      repeat (4) begin
         @(posedge clk);
         if (s0_ready)
            fail_check("s0 accepted while halted");
      end
      @(negedge clk);
      handle_int = 1'b1;
      @(negedge clk);
      handle_int = 1'b0;
      wait_accept(waited);
      // Held slot is dropped by flush
      ready_mode <= 2'd2;
      offer(alu_instr(1'b0), 1'b0);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      exp_q.delete();
      if (s1_valid)
         fail_check("slot still valid after flush");
      ready_mode <= 2'd0;
      // PUSHA cut after three micro-ops while still offered, then offered again
      ins = rom_instr(3'(decode_pkg::ROM_PUSHA));
      present(ins);
      repeat (3) @(posedge clk);
      @(negedge clk);
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      exp_q.delete();
      offer(ins, 1'b0);
      if (waited != 8)
         fail_check("PUSHA did not restart from micro-op 0 after flush");
      end_test();

      $display("Tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- Bender.yml
package:
  name: decode_stage_1

sources:
  - hw/decode_pkg.sv
  - hw/imm_disp_split.sv
  - hw/prefix_decode.sv
  - hw/op_and_rm_decode.sv
  - hw/rom_sequencer.sv
  - hw/decode_stage_1.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_decode_stage_1.sv

//--- tb.f
+incdir+testbench
hw/decode_pkg.sv
hw/imm_disp_split.sv
hw/prefix_decode.sv
hw/op_and_rm_decode.sv
hw/rom_sequencer.sv
hw/decode_stage_1.sv
testbench/tb_decode_stage_1.sv
